// File: design/scc_pkg.sv
/*
 * Shared definitions for the dual wavetable sound device.
 * Holds the CPU bus and device select structs, the configuration
 * write struct, the register map of both chip layouts and the
 * register field encoding used by the address decoder.
 */
package scc_pkg;

    // Chip count, channels per chip and waveform length in bytes
    localparam int NUM_CHIPS = 2;
    localparam int NUM_CHAN  = 5;
    localparam int WAVE_LEN  = 32;

    // Start of the register block in each layout. Everything below it is waveform RAM
    localparam logic [7:0] REG_BASE_CLASSIC = 8'h80;
    localparam logic [7:0] REG_BASE_PLUS    = 8'hA0;

    // Field offsets inside the register block, identical for both layouts
    // Periods take offsets 00 to 09 as low/high byte pairs
    localparam logic [7:0] OFS_VOLUME = 8'h0A;
    localparam logic [7:0] OFS_ENABLE = 8'h0F;

    // Periods below this value stop the waveform index
    localparam logic [11:0] MIN_PERIOD = 12'd9;

    // Device types found on the select and configuration buses
    typedef enum logic [3:0] {
        DEV_NONE = 4'h0,
        DEV_SCC  = 4'h1,
        DEV_PSG  = 4'h2,
        DEV_OPLL = 4'h3
    } dev_type_e;

    // Register field addressed by a bus cycle
    typedef enum logic [2:0] {
        FLD_WAVE,
        FLD_PERIOD_LO,
        FLD_PERIOD_HI,
        FLD_VOLUME,
        FLD_ENABLE,
        FLD_NONE
    } chan_field_e;

    // One CPU bus cycle, request qualified by the clock enable
    typedef struct packed {
        logic       req;
        logic       wr;
        logic       rd;
        logic [7:0] addr;
        logic [7:0] wdata;
    } cpu_req_t;

    // Device select that comes with each bus cycle
    typedef struct packed {
        logic      en;
        dev_type_e typ;
        logic [1:0] num;
    } dev_sel_t;

    // A configuration write for one device instance
    typedef struct packed {
        logic       valid;
        dev_type_e  typ;
        logic [1:0] num;
        logic       mode;
        logic       plus;
    } dev_cfg_t;

endpackage

// File: design/scc_wave_ram.sv
/*
 * Waveform memory of one wavetable chip.
 * Five 32-byte signed waveforms with one CPU port for writes and
 * reads and one playback port per channel. In the classic layout
 * a write to channel 3 lands in channel 4 as well.
 */
`timescale 1ns/10ps

module scc_wave_ram (
    input  logic              cpu_bus,
    input  logic              wr_en,
    input  logic [7:0]        addr,
    input  logic [7:0]        wdata,
    input  logic              plus_mode,
    output logic [7:0]        rdata,
    input  logic [4:0]        play_idx [scc_pkg::NUM_CHAN],
    output logic signed [7:0] play_sample [scc_pkg::NUM_CHAN]
);
    import scc_pkg::*;

    logic [7:0] wave_mem [NUM_CHAN][WAVE_LEN];

    // The upper address bits pick the channel, the lower five the byte
    logic [2:0]          addr_chan;
    logic [4:0]          addr_idx;
    logic [NUM_CHAN-1:0] wr_hit;

    assign addr_chan = addr[7:5];
    assign addr_idx  = addr[4:0];

    // Channel write hits, with channel 4 following channel 3 in the classic layout
    always_comb begin
        for (int c = 0; c < NUM_CHAN; c++) begin
            wr_hit[c] = (addr_chan == 3'(c));
        end
        if (!plus_mode && addr_chan == 3'(NUM_CHAN - 2)) begin
            wr_hit[NUM_CHAN-1] = 1'b1;
        end
    end

    // Payload storage, written only through the decoded strobe
    always_ff @(posedge cpu_bus) begin
        for (int c = 0; c < NUM_CHAN; c++) begin
            if (wr_en && wr_hit[c]) begin
                wave_mem[c][addr_idx] <= wdata;
            end
        end
    end

    // CPU read port
    // The decoder only forwards wave-area addresses, the guard keeps the index in range
    always_comb begin
        if (addr_chan < 3'(NUM_CHAN)) begin
            rdata = wave_mem[addr_chan][addr_idx];
        end else begin
            rdata = 8'hFF;
        end
    end

    // Playback ports, one byte per channel at its current index
    always_comb begin
        for (int c = 0; c < NUM_CHAN; c++) begin
            play_sample[c] = signed'(wave_mem[c][play_idx[c]]);
        end
    end

endmodule

// File: design/scc_tone_gen.sv
/*
 * Tone generator of one wavetable chip.
 * One 12-bit down-counter per channel steps that channel's
 * waveform index once every period+1 clock enables. Channels with
 * a period below the minimum keep their index.
 */
`timescale 1ns/10ps

module scc_tone_gen (
    input  logic        cpu_bus,
    input  logic        arst_n,
    input  logic        clk_en,
    input  logic [11:0] period [scc_pkg::NUM_CHAN],
    output logic [4:0]  play_idx [scc_pkg::NUM_CHAN]
);
    import scc_pkg::*;

    logic [11:0]         cnt [NUM_CHAN];
    logic [NUM_CHAN-1:0] chan_run;
    logic [NUM_CHAN-1:0] chan_wrap;

    // Per-channel run and wrap conditions
    always_comb begin
        for (int c = 0; c < NUM_CHAN; c++) begin
            // Very short periods would alias, so such a channel just holds
            chan_run[c]  = (period[c] >= MIN_PERIOD);
            // The counter wraps when it has run down to zero
            chan_wrap[c] = (cnt[c] == 12'd0);
        end
    end

    // Down-counters and waveform indices
    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < NUM_CHAN; c++) begin
                cnt[c]      <= 12'd0;
                play_idx[c] <= 5'd0;
            end
        end else if (clk_en) begin
            for (int c = 0; c < NUM_CHAN; c++) begin
                if (!chan_run[c]) begin
                    // Keep the counter loaded so that the channel restarts cleanly
                    // once a valid period is written
                    cnt[c] <= period[c];
                end else if (chan_wrap[c]) begin
                    // A full period has passed, reload and move to the next byte
                    cnt[c]      <= period[c];
                    play_idx[c] <= play_idx[c] + 5'd1;
                end else begin
                    cnt[c] <= cnt[c] - 12'd1;
                end
            end
        end
    end

endmodule

// File: design/scc_mixer.sv
/*
 * Channel mixer of one wavetable chip.
 * Scales each channel's sample by its 4-bit volume, drops the
 * disabled channels and registers the sum on the clock enable.
 */
`timescale 1ns/10ps

module scc_mixer (
    input  logic               cpu_bus,
    input  logic               arst_n,
    input  logic               clk_en,
    input  logic signed [7:0]  play_sample [scc_pkg::NUM_CHAN],
    input  logic [3:0]         volume [scc_pkg::NUM_CHAN],
    input  logic [4:0]         chan_enable,
    output logic signed [14:0] wave
);
    import scc_pkg::*;

    // A signed 8-bit sample times a volume of at most 15 fits in 13 bits
    logic signed [12:0] prod [NUM_CHAN];
    logic signed [14:0] mix_sum;

    // Volume is unsigned, so it gets a zero sign bit before the product
    always_comb begin
        for (int c = 0; c < NUM_CHAN; c++) begin
            if (chan_enable[c]) begin
                prod[c] = play_sample[c] * $signed({1'b0, volume[c]});
            end else begin
                prod[c] = 13'sd0;
            end
        end
    end

    // Five products of at most 1920 in magnitude stay inside 15 bits
    always_comb begin
        mix_sum = 15'sd0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            mix_sum = mix_sum + prod[c];
        end
    end

    // Output register, one clock enable of latency
    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            wave <= 15'sd0;
        end else if (clk_en) begin
            wave <= mix_sum;
        end
    end

endmodule

// File: design/scc_wave.sv
/*
 * One complete wavetable chip.
 * Decodes the bus address into a register field for the active
 * layout, holds the period, volume and enable registers, answers
 * reads from the waveform area and ties together the waveform RAM,
 * the tone generator and the mixer.
 */
`timescale 1ns/10ps

module scc_wave (
    input  logic               cpu_bus,
    input  logic               arst_n,
    input  logic               clk_en,
    input  logic               sel,
    input  scc_pkg::cpu_req_t  bus,
    input  logic               plus_mode,
    output logic [7:0]         rdata,
    output logic signed [14:0] wave
);
    import scc_pkg::*;

    logic [7:0]          reg_base;
    logic [7:0]          reg_ofs;
    chan_field_e         field;
    logic [2:0]          chan;
    logic                wr_strobe;
    logic [11:0]         period [NUM_CHAN];
    logic [3:0]          volume [NUM_CHAN];
    logic [NUM_CHAN-1:0] chan_enable;
    logic [4:0]          play_idx [NUM_CHAN];
    logic signed [7:0]   play_sample [NUM_CHAN];
    logic [7:0]          ram_rdata;

    // The register block sits right after the waveform area of the layout
    assign reg_base = plus_mode ? REG_BASE_PLUS : REG_BASE_CLASSIC;
    assign reg_ofs  = bus.addr - reg_base;

    // Address decode into a field and a channel number
    always_comb begin
        field = FLD_NONE;
        chan  = 3'd0;
        if (bus.addr < reg_base) begin
            field = FLD_WAVE;
        end else if (reg_ofs < OFS_VOLUME) begin
            // Period pairs, low byte at the even offset
            field = reg_ofs[0] ? FLD_PERIOD_HI : FLD_PERIOD_LO;
            chan  = reg_ofs[3:1];
        end else if (reg_ofs < OFS_ENABLE) begin
            field = FLD_VOLUME;
            chan  = 3'(reg_ofs - OFS_VOLUME);
        end else if (reg_ofs == OFS_ENABLE) begin
            field = FLD_ENABLE;
        end
    end

    // A write is taken on every qualified cycle, there is no back-pressure
    assign wr_strobe = clk_en && sel && bus.req && bus.wr;

    // Channel registers
    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < NUM_CHAN; c++) begin
                period[c] <= 12'd0;
                volume[c] <= 4'd0;
            end
            chan_enable <= '0;
        end else if (wr_strobe) begin
            case (field)
                FLD_PERIOD_LO: period[chan][7:0]  <= bus.wdata;
                FLD_PERIOD_HI: period[chan][11:8] <= bus.wdata[3:0];
                FLD_VOLUME:    volume[chan]       <= bus.wdata[3:0];
                FLD_ENABLE:    chan_enable        <= bus.wdata[NUM_CHAN-1:0];
                default: ;
            endcase
        end
    end

    // Only the waveform area reads back, all else returns an idle bus
    assign rdata = (sel && bus.rd && field == FLD_WAVE) ? ram_rdata : 8'hFF;

    scc_wave_ram ram_i (
        .cpu_bus     (cpu_bus),
        .wr_en       (wr_strobe && field == FLD_WAVE),
        .addr        (bus.addr),
        .wdata       (bus.wdata),
        .plus_mode   (plus_mode),
        .rdata       (ram_rdata),
        .play_idx    (play_idx),
        .play_sample (play_sample)
    );

    scc_tone_gen tone_i (
        .cpu_bus  (cpu_bus),
        .arst_n   (arst_n),
        .clk_en   (clk_en),
        .period   (period),
        .play_idx (play_idx)
    );

    scc_mixer mixer_i (
        .cpu_bus     (cpu_bus),
        .arst_n      (arst_n),
        .clk_en      (clk_en),
        .play_sample (play_sample),
        .volume      (volume),
        .chan_enable (chan_enable),
        .wave        (wave)
    );

endmodule

// File: design/dev_scc.sv
/*
 * Dual wavetable sound device.
 * Two chips share one CPU bus. The device latches each chip's
 * layout bits from the configuration bus, selects a chip from the
 * device select, returns its read data and sums the outputs of the
 * enabled slots into one signed 16-bit sample.
 */
`timescale 1ns/10ps

module dev_scc (
    input  logic               cpu_bus,
    input  logic               arst_n,
    input  logic               clk_en,
    input  scc_pkg::cpu_req_t  bus,
    input  scc_pkg::dev_sel_t  sel,
    input  scc_pkg::dev_cfg_t  cfg,
    input  logic [1:0]         slot_enable,
    output logic signed [15:0] sound,
    output logic [7:0]         data
);
    import scc_pkg::*;

    logic [NUM_CHIPS-1:0] chip_mode;
    logic [NUM_CHIPS-1:0] chip_plus;
    logic [NUM_CHIPS-1:0] chip_sel;
    logic [7:0]           chip_rdata [NUM_CHIPS];
    logic signed [14:0]   chip_wave [NUM_CHIPS];
    logic signed [15:0]   sound_sum;
    logic [7:0]           rd_mux;

    // The configuration latch ignores a write for another device or a third instance
    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            chip_mode <= '0;
            chip_plus <= '0;
        end else if (cfg.valid && cfg.typ == DEV_SCC) begin
            for (int i = 0; i < NUM_CHIPS; i++) begin
                if (cfg.num == 2'(i)) begin
                    chip_mode[i] <= cfg.mode;
                    chip_plus[i] <= cfg.plus;
                end
            end
        end
    end

    // Chip select straight from the device select
    always_comb begin
        for (int i = 0; i < NUM_CHIPS; i++) begin
            chip_sel[i] = sel.en && sel.typ == DEV_SCC && sel.num == 2'(i);
        end
    end

    // The plus layout needs a plus-capable chip that is also switched into plus mode
    for (genvar i = 0; i < NUM_CHIPS; i++) begin : g_chip
        scc_wave scc_i (
            .cpu_bus   (cpu_bus),
            .arst_n    (arst_n),
            .clk_en    (clk_en),
            .sel       (chip_sel[i]),
            .bus       (bus),
            .plus_mode (chip_mode[i] && chip_plus[i]),
            .rdata     (chip_rdata[i]),
            .wave      (chip_wave[i])
        );
    end

    // A chip returns all ones unless it sees a read, and so does an idle bus
    always_comb begin
        rd_mux = 8'hFF;
        for (int i = 0; i < NUM_CHIPS; i++) begin
            if (chip_sel[i]) begin
                rd_mux = chip_rdata[i];
            end
        end
    end

    assign data = rd_mux;

    // Each chip output is sign-extended by one bit before it enters the slot sum
    always_comb begin
        sound_sum = 16'sd0;
        for (int i = 0; i < NUM_CHIPS; i++) begin
            if (slot_enable[i]) begin
                sound_sum = sound_sum + $signed({chip_wave[i][14], chip_wave[i]});
            end
        end
    end

    assign sound = sound_sum;

endmodule

// File: tests/scc_clock_gen.sv
/*
 * Testbench clock and reset source.
 * Runs an 8 ns clock and holds the active-low reset for the first
 * 16 rising edges.
 */
`timescale 1ns/10ps

module scc_clock_gen (
    output logic cpu_bus,
    output logic arst_n
);

    initial begin
        cpu_bus = 1'b0;
        arst_n  = 1'b0;
        // Release on a rising edge, just like any other driven input
        repeat (16) @(posedge cpu_bus);
        arst_n <= 1'b1;
    end

    // Half period of 4 ns
    always #4 cpu_bus = ~cpu_bus;

endmodule

// File: tests/scc_props.sv
/*
 * Bound assertions on the outputs of the dual wavetable device.
 * Covers the idle read value, the muted sum with no slot enabled
 * and the output values during reset.
 */
`timescale 1ns/10ps

module scc_props (
    input logic               cpu_bus,
    input logic               arst_n,
    input scc_pkg::cpu_req_t  bus,
    input scc_pkg::dev_sel_t  sel,
    input logic [1:0]         slot_enable,
    input logic signed [15:0] sound,
    input logic [7:0]         data
);
    import scc_pkg::*;

    logic chip_addressed;

    // Only select numbers that name an existing chip count as a select
    assign chip_addressed = sel.en && sel.typ == DEV_SCC && int'(sel.num) < NUM_CHIPS;

    // Without a read to a selected chip the bus floats high
    idle_read_a: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        (!bus.rd || !chip_addressed) |-> data == 8'hFF)
        else $error("data is not FF on an unselected or non-read cycle");

    // No slot enabled means silence
    muted_a: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        slot_enable == 2'b00 |-> sound == 16'sd0)
        else $error("sound is not zero with both slots disabled");

    // Outputs sit at their reset values while reset is held
    reset_a: assert property (@(posedge cpu_bus)
        !arst_n |-> (sound == 16'sd0 && data == 8'hFF))
        else $error("outputs left their reset values during reset");

endmodule

bind dev_scc scc_props props_i (
    .cpu_bus     (cpu_bus),
    .arst_n      (arst_n),
    .bus         (bus),
    .sel         (sel),
    .slot_enable (slot_enable),
    .sound       (sound),
    .data        (data)
);

// File: tests/scc_tb.sv
/*
 * Directed testbench for the dual wavetable sound device.
 * Checks reset values, waveform readback, idle reads, the volume
 * scaled channel sum over both slots and the two register layouts.
 */
`timescale 1ns/10ps

module scc_tb;
    import scc_pkg::*;

    // The tests take roughly 1000 cycles, which go mostly to waveform fills and readback
    localparam int CYCLE_LIMIT = 4000;

    logic               cpu_bus;
    logic               arst_n;
    logic               clk_en;
    cpu_req_t           bus;
    dev_sel_t           sel;
    dev_cfg_t           cfg;
    logic [1:0]         slot_enable;
    logic signed [15:0] sound;
    logic [7:0]         data;
    integer             seed;
    int                 cycle_count;
    int                 fail_count;
    logic [7:0]         wave_img [NUM_CHIPS][128];

    scc_clock_gen clk_i (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n)
    );

    dev_scc dut_i (
        .cpu_bus     (cpu_bus),
        .arst_n      (arst_n),
        .clk_en      (clk_en),
        .bus         (bus),
        .sel         (sel),
        .cfg         (cfg),
        .slot_enable (slot_enable),
        .sound       (sound),
        .data        (data)
    );

    // Device select naming one chip number
    function automatic dev_sel_t chip_select(input int num);
        dev_sel_t s;
        s.en  = 1'b1;
        s.typ = DEV_SCC;
        s.num = 2'(num);
        return s;
    endfunction

    // Register address of a field in the given layout
    function automatic logic [7:0] reg_addr(input logic plus, input chan_field_e fld,
                                            input int chan);
        logic [7:0] base;
        logic [7:0] ofs;
        base = plus ? REG_BASE_PLUS : REG_BASE_CLASSIC;
        case (fld)
            FLD_PERIOD_LO: ofs = 8'(2 * chan);
            FLD_PERIOD_HI: ofs = 8'(2 * chan + 1);
            FLD_VOLUME:    ofs = 8'(10 + chan);
            FLD_ENABLE:    ofs = 8'h0F;
            default:       ofs = 8'h00;
        endcase
        return base + ofs;
    endfunction

    // Contribution of one channel with a constant waveform
    function automatic int chan_term(input logic [7:0] sample, input int vol);
        int s;
        s = $signed(sample);
        return s * vol;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            fail_count++;
            $display("error: %s is %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic bus_write(input int chip, input logic [7:0] addr, input logic [7:0] wdata);
        cpu_req_t r;
        r.req   = 1'b1;
        r.wr    = 1'b1;
        r.rd    = 1'b0;
        r.addr  = addr;
        r.wdata = wdata;
        @(posedge cpu_bus);
        bus <= r;
        sel <= chip_select(chip);
    endtask

    // Reads are combinational, so the value is taken mid-cycle
    task automatic bus_read(input dev_sel_t s, input logic [7:0] addr, output logic [7:0] rd);
        cpu_req_t r;
        r.req   = 1'b1;
        r.wr    = 1'b0;
        r.rd    = 1'b1;
        r.addr  = addr;
        r.wdata = 8'h00;
        @(posedge cpu_bus);
        bus <= r;
        sel <= s;
        @(negedge cpu_bus);
        rd = data;
    endtask

    task automatic idle_cycles(input int n);
        @(posedge cpu_bus);
        bus <= '0;
        sel <= '0;
        repeat (n - 1) @(posedge cpu_bus);
    endtask

    task automatic set_slots(input logic [1:0] slots);
        @(posedge cpu_bus);
        slot_enable <= slots;
    endtask

    task automatic write_cfg(input int chip, input logic plus_layout);
        dev_cfg_t c;
        c.valid = 1'b1;
        c.typ   = DEV_SCC;
        c.num   = 2'(chip);
        c.mode  = plus_layout;
        c.plus  = plus_layout;
        @(posedge cpu_bus);
        cfg <= c;
        @(posedge cpu_bus);
        cfg <= '0;
    endtask

    task automatic fill_wave(input int chip, input int chan, input logic [7:0] value);
        for (int i = 0; i < WAVE_LEN; i++) begin
            bus_write(chip, 8'(chan * WAVE_LEN + i), value);
        end
    endtask

    task automatic set_channel(input int chip, input logic plus, input int chan,
                               input logic [11:0] period, input logic [3:0] vol);
        bus_write(chip, reg_addr(plus, FLD_PERIOD_LO, chan), period[7:0]);
        bus_write(chip, reg_addr(plus, FLD_PERIOD_HI, chan), {4'h0, period[11:8]});
        bus_write(chip, reg_addr(plus, FLD_VOLUME, chan), {4'h0, vol});
    endtask

    // The mixer register needs settling time after the last write
    task automatic expect_sound(input int exp);
        idle_cycles(10);
        @(negedge cpu_bus);
        check_value("sound", sound, 16'(exp));
    endtask

    // Both slots are enabled here, so sound reflects the reset state of the chips
    task automatic test_reset_values();
        @(negedge cpu_bus);
        check_value("sound", sound, 16'h0000);
        check_value("data", {8'h00, data}, 16'h00FF);
    endtask

    // Both chips are filled first so that a write leaking into the other shows up
    task automatic test_wave_readback();
        logic [7:0] rd;
        for (int chip = 0; chip < NUM_CHIPS; chip++) begin
            for (int a = 0; a < 128; a++) begin
                wave_img[chip][a] = 8'($random(seed));
                bus_write(chip, 8'(a), wave_img[chip][a]);
            end
        end
        for (int chip = 0; chip < NUM_CHIPS; chip++) begin
            for (int a = 0; a < 128; a++) begin
                bus_read(chip_select(chip), 8'(a), rd);
                check_value("data", {8'h00, rd}, {8'h00, wave_img[chip][a]});
            end
        end
    endtask

    task automatic test_idle_reads();
        logic [7:0] rd;
        dev_sel_t   s;
        bus_read(chip_select(0), reg_addr(1'b0, FLD_PERIOD_LO, 2), rd);
        check_value("data", {8'h00, rd}, 16'h00FF);
        s = chip_select(0);
        s.en = 1'b0;
        bus_read(s, 8'h00, rd);
        check_value("data", {8'h00, rd}, 16'h00FF);
        bus_read(chip_select(2), 8'h00, rd);
        check_value("data", {8'h00, rd}, 16'h00FF);
        s = chip_select(1);
        s.typ = DEV_PSG;
        bus_read(s, 8'h00, rd);
        check_value("data", {8'h00, rd}, 16'h00FF);
    endtask

    task automatic test_single_channel();
        fill_wave(0, 0, 8'hD3);
        set_channel(0, 1'b0, 0, 12'd0, 4'd11);
        bus_write(0, reg_addr(1'b0, FLD_ENABLE, 0), 8'h01);
        set_slots(2'b01);
        expect_sound(chan_term(8'hD3, 11));
        set_slots(2'b00);
        expect_sound(0);
    endtask

    // Channel 0 of chip 0 keeps its setup from the previous test
    task automatic test_channel_sum();
        int chip0_sum;
        int chip1_sum;
        fill_wave(0, 1, 8'h47);
        set_channel(0, 1'b0, 1, 12'd5, 4'd9);
        fill_wave(0, 2, 8'h9C);
        set_channel(0, 1'b0, 2, 12'd100, 4'd15);
        bus_write(0, reg_addr(1'b0, FLD_ENABLE, 0), 8'h07);
        fill_wave(1, 0, 8'h21);
        set_channel(1, 1'b0, 0, 12'd300, 4'd6);
        fill_wave(1, 3, 8'hF0);
        set_channel(1, 1'b0, 3, 12'd5, 4'd4);
        bus_write(1, reg_addr(1'b0, FLD_ENABLE, 0), 8'h09);
        chip0_sum = chan_term(8'hD3, 11) + chan_term(8'h47, 9) + chan_term(8'h9C, 15);
        chip1_sum = chan_term(8'h21, 6) + chan_term(8'hF0, 4);
        set_slots(2'b11);
        expect_sound(chip0_sum + chip1_sum);
        set_slots(2'b01);
        expect_sound(chip0_sum);
        set_slots(2'b10);
        expect_sound(chip1_sum);
    endtask

    task automatic test_layouts();
        logic [7:0] rd;
        set_slots(2'b01);
        // In the classic layout channel 4 plays what was written to channel 3
        bus_write(0, reg_addr(1'b0, FLD_ENABLE, 0), 8'h10);
        fill_wave(0, 3, 8'h5A);
        bus_write(0, reg_addr(1'b0, FLD_VOLUME, 4), 8'h07);
        expect_sound(chan_term(8'h5A, 7));
        bus_read(chip_select(0), 8'h80, rd);
        check_value("data", {8'h00, rd}, 16'h00FF);
        // In the plus layout channel 4 gets its own waveform at 80
        write_cfg(0, 1'b1);
        fill_wave(0, 4, 8'hB5);
        expect_sound(chan_term(8'hB5, 7));
        bus_read(chip_select(0), 8'h80, rd);
        check_value("data", {8'h00, rd}, 16'h00B5);
        bus_write(0, reg_addr(1'b1, FLD_VOLUME, 4), 8'h0D);
        expect_sound(chan_term(8'hB5, 13));
        // Channel 3 no longer mirrors into channel 4
        fill_wave(0, 3, 8'h11);
        expect_sound(chan_term(8'hB5, 13));
        // Chip 1 stayed in the classic layout
        bus_read(chip_select(1), 8'h80, rd);
        check_value("data", {8'h00, rd}, 16'h00FF);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count <= CYCLE_LIMIT) begin
            @(posedge cpu_bus);
            cycle_count++;
        end
        $display("TEST FAILED");
        $fatal(1, "simulation ran past the cycle limit");
    end

    initial begin
        seed        = 32'h3ee3_0b0a;
        fail_count  = 0;
        clk_en      = 1'b1;
        bus         = '0;
        sel         = '0;
        cfg         = '0;
        slot_enable = 2'b11;
        @(posedge arst_n);
        test_reset_values();
        test_wave_readback();
        test_idle_reads();
        test_single_channel();
        test_channel_sum();
        test_layouts();
        if (fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: dev_scc.f
design/scc_pkg.sv
design/scc_wave_ram.sv
design/scc_tone_gen.sv
design/scc_mixer.sv
design/scc_wave.sv
design/dev_scc.sv
tests/scc_clock_gen.sv
tests/scc_props.sv
tests/scc_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status of the simulation is the test result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    -f dev_scc.f --top-module scc_tb \
    -Mdir build -o scc_sim
./build/scc_sim
